//--- design/fv_bank_cntl.sv
// one feature-vector bank: writes off-chip load frames and streams read bursts to an edge PE
`timescale 1ns/1ps

module fv_bank_cntl (
    input  logic                clk,
    input  logic                reset,
    input  fv_pkg::fv_num_t     num_fv,
    input  logic                start,
    input  fv_pkg::bank_addr_t  start_addr,
    input  fv_pkg::pe_tag_t     start_tag,
    input  logic                ld_sos,
    input  logic                ld_eos,
    input  fv_pkg::bank_addr_t  ld_a,
    input  fv_pkg::fv_data_t    ld_data,
    input  fv_pkg::fv_data_t    sram_q,
    fv_sram_if.bank             sram,
    fv_stream_if.source         pe,
    output logic                busy
);
    import fv_pkg::*;

    bank_state_t state;
    fv_num_t     remaining;
    bank_addr_t  rd_addr;
    pe_tag_t     burst_tag;
    logic        ld_active;
    logic        ld_we;
    logic        rd_en;
    logic        last_rd;

    assign busy    = (state != BANK_IDLE);
    assign rd_en   = (state == BANK_READ);
    assign last_rd = (remaining == fv_num_t'(1));
    assign ld_we   = (ld_sos || ld_active) && !busy;

    // inside a load frame, sos through eos
    always_ff @(posedge clk) begin
        if (reset)
            ld_active <= 1'b0;
        else if (ld_eos)
            ld_active <= 1'b0;
        else if (ld_sos)
            ld_active <= 1'b1;
    end

    assign sram.cen = !(ld_we || rd_en);
    assign sram.wen = !ld_we;
    assign sram.a   = rd_en ? rd_addr : ld_a;
    assign sram.d   = ld_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= BANK_IDLE;
            remaining <= '0;
        end else begin
            case (state)
                BANK_IDLE: begin
                    if (start) begin
                        state     <= BANK_READ;
                        remaining <= num_fv;
                    end
                end
                BANK_READ: begin
                    remaining <= remaining - 1'b1;
                    if (last_rd)
                        state <= BANK_DRAIN;
                end
                // last word is on the stream now
                BANK_DRAIN: state <= BANK_IDLE;
                default:    state <= BANK_IDLE;
            endcase
        end
    end

    // address wraps mod 256 by width
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            rd_addr   <= start_addr;
            burst_tag <= start_tag;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // flags line up with sram_q, one cycle after the read
    always_ff @(posedge clk) begin
        if (reset) begin
            pe.valid <= 1'b0;
            pe.sos   <= 1'b0;
            pe.eos   <= 1'b0;
        end else begin
            pe.valid <= rd_en;
            // first read always follows an idle gap on the stream
            pe.sos   <= rd_en && !pe.valid;
            pe.eos   <= rd_en && last_rd;
        end
    end

    assign pe.tag  = burst_tag;
    assign pe.data = sram_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy);
    a_no_load_busy: assert property (@(posedge clk) disable iff (reset) ld_sos |-> !busy);

endmodule

//--- design/fv_bus.sv
// routes each bank stream to the edge PE named by its tag, one register stage
`timescale 1ns/1ps

module fv_bus (
    input  logic                                        clk,
    input  logic                                        reset,
    fv_stream_if.sink                                   bank [fv_pkg::NUM_BANKS],
    output logic [fv_pkg::NUM_EDGE_PE-1:0]              pe_valid,
    output logic [fv_pkg::NUM_EDGE_PE-1:0]              pe_sos,
    output logic [fv_pkg::NUM_EDGE_PE-1:0]              pe_eos,
    output fv_pkg::fv_data_t [fv_pkg::NUM_EDGE_PE-1:0]  pe_data
);
    import fv_pkg::*;

    logic [NUM_BANKS-1:0]             b_valid;
    logic [NUM_BANKS-1:0]             b_sos;
    logic [NUM_BANKS-1:0]             b_eos;
    pe_tag_t                          b_tag  [NUM_BANKS];
    fv_data_t                         b_data [NUM_BANKS];
    logic [NUM_BANKS-1:0]             hit    [NUM_EDGE_PE];
    logic [NUM_EDGE_PE-1:0]           sel_valid;
    logic [NUM_EDGE_PE-1:0]           sel_sos;
    logic [NUM_EDGE_PE-1:0]           sel_eos;
    fv_data_t [NUM_EDGE_PE-1:0]       sel_data;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign b_valid[b] = bank[b].valid;
        assign b_sos[b]   = bank[b].sos;
        assign b_eos[b]   = bank[b].eos;
        assign b_tag[b]   = bank[b].tag;
        assign b_data[b]  = bank[b].data;
    end

    // at most one bank serves a tag, so a plain OR-mux is enough
    always_comb begin
        for (int p = 0; p < NUM_EDGE_PE; p++) begin
            sel_sos[p]  = 1'b0;
            sel_eos[p]  = 1'b0;
            sel_data[p] = '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                hit[p][b] = b_valid[b] && (b_tag[b] == pe_tag_t'(p));
                if (hit[p][b]) begin
                    sel_sos[p]  = b_sos[b];
                    sel_eos[p]  = b_eos[b];
                    sel_data[p] = b_data[b];
                end
            end
            sel_valid[p] = |hit[p];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pe_valid <= '0;
            pe_sos   <= '0;
            pe_eos   <= '0;
        end else begin
            pe_valid <= sel_valid;
            pe_sos   <= sel_sos;
            pe_eos   <= sel_eos;
        end
    end

    always_ff @(posedge clk) begin
        pe_data <= sel_data;
    end

    // tag exclusivity comes from the memory controller
    for (genvar p = 0; p < NUM_EDGE_PE; p++) begin : g_pe_chk
        a_tag_exclusive: assert property (@(posedge clk) disable iff (reset) $onehot0(hit[p]));
    end

endmodule

//--- design/fv_ifs.sv
// bank-to-SRAM port and bank-to-bus stream interfaces used inside the feature-vector subsystem
`timescale 1ns/1ps

// cen and wen active low
interface fv_sram_if;
    import fv_pkg::*;

    logic       cen;
    logic       wen;
    bank_addr_t a;
    fv_data_t   d;

    modport bank (output cen, output wen, output a, output d);
    modport sram (input cen, input wen, input a, input d);

endinterface

// framed burst toward one edge PE, selected by tag
interface fv_stream_if;
    import fv_pkg::*;

    logic     valid;
    logic     sos;
    logic     eos;
    pe_tag_t  tag;
    fv_data_t data;

    modport source (output valid, output sos, output eos, output tag, output data);
    modport sink (input valid, input sos, input eos, input tag, input data);

endinterface

//--- design/fv_mem_cntl.sv
// pops the request FIFO head and dispatches it to its bank once both bank and PE tag are free
`timescale 1ns/1ps

module fv_mem_cntl (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             rempty,
    input  fv_pkg::fv_addr_t                 rdata_addr,
    input  fv_pkg::pe_tag_t                  rdata_tag,
    input  logic [fv_pkg::NUM_BANKS-1:0]     bank_busy,
    output logic                             rinc,
    output logic [fv_pkg::NUM_BANKS-1:0]     start,
    output fv_pkg::bank_addr_t               start_addr,
    output fv_pkg::pe_tag_t                  start_tag
);
    import fv_pkg::*;

    bank_sel_t            head_bank;
    bank_addr_t           head_addr;
    pe_tag_t              serving_tag [NUM_BANKS];
    logic [NUM_BANKS-1:0] occupied;
    logic                 tag_hit;

    assign head_bank = rdata_addr[BANK_SEL_WIDTH-1:0];
    assign head_addr = rdata_addr[FV_INFO_BANK_WIDTH-1:BANK_SEL_WIDTH];

    // a start in flight counts as busy since the bank raises busy a cycle later
    assign occupied = bank_busy | start;

    always_comb begin
        tag_hit = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (occupied[b] && (serving_tag[b] == rdata_tag))
                tag_hit = 1'b1;
        end
    end

    assign rinc = !rempty && !occupied[head_bank] && !tag_hit;

    always_ff @(posedge clk) begin
        if (reset)
            start <= '0;
        else
            start <= rinc ? (NUM_BANKS'(1) << head_bank) : '0;
    end

    always_ff @(posedge clk) begin
        if (rinc) begin
            start_addr             <= head_addr;
            start_tag              <= rdata_tag;
            serving_tag[head_bank] <= rdata_tag;
        end
    end

    // the addressed bank must turn busy right after its start
    a_start_taken: assert property (@(posedge clk) disable iff (reset)
        (start != '0) |=> ((bank_busy & $past(start)) != '0));

endmodule

//--- design/fv_pkg.sv
// sizes, address types and bank FSM states shared by the feature-vector SRAM blocks
package fv_pkg;

    localparam int NUM_BANKS          = 4;
    localparam int NUM_EDGE_PE        = 4;
    localparam int FV_BANDWIDTH       = 16;
    localparam int FV_INFO_BANK_WIDTH = 10;
    localparam int SRAM_DEPTH         = 256;
    localparam int MAX_FV_NUM         = 8;
    localparam int FIFO_DEPTH         = 8;

    // derived widths
    localparam int BANK_SEL_WIDTH  = $clog2(NUM_BANKS);
    localparam int BANK_ADDR_WIDTH = $clog2(SRAM_DEPTH);
    localparam int PE_TAG_WIDTH    = $clog2(NUM_EDGE_PE);
    localparam int FV_NUM_WIDTH    = $clog2(MAX_FV_NUM) + 1;
    localparam int FIFO_PTR_WIDTH  = $clog2(FIFO_DEPTH);

    typedef logic [FV_BANDWIDTH-1:0]       fv_data_t;
    typedef logic [FV_INFO_BANK_WIDTH-1:0] fv_addr_t;
    typedef logic [BANK_ADDR_WIDTH-1:0]    bank_addr_t;
    typedef logic [BANK_SEL_WIDTH-1:0]     bank_sel_t;
    typedef logic [PE_TAG_WIDTH-1:0]       pe_tag_t;

    // burst length, 1 to MAX_FV_NUM
    typedef logic [FV_NUM_WIDTH-1:0] fv_num_t;

    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_READ,
        BANK_DRAIN
    } bank_state_t;

endpackage

//--- design/fv_sram.sv
// behavioral single-port 256x16 bank SRAM, registered read output
`timescale 1ns/1ps

module fv_sram (
    input  logic              clk,
    fv_sram_if.sram           sram,
    output fv_pkg::fv_data_t  q
);
    import fv_pkg::*;

    fv_data_t mem [SRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (!sram.cen) begin
            if (!sram.wen)
                mem[sram.a] <= sram.d;
            else
                q <= mem[sram.a];
        end
    end

endmodule

//--- design/fv_sram_top.sv
// feature-vector SRAM subsystem top, request FIFO to banks to edge-PE outputs, flat ports
`timescale 1ns/1ps

module fv_sram_top (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        wdata_valid,
    input  fv_pkg::fv_addr_t                            wdata_fv_addr,
    input  fv_pkg::pe_tag_t                             wdata_pe_tag,
    input  fv_pkg::fv_num_t                             num_fv,
    input  logic [fv_pkg::NUM_BANKS-1:0]                ld_sos,
    input  logic [fv_pkg::NUM_BANKS-1:0]                ld_eos,
    input  fv_pkg::fv_data_t [fv_pkg::NUM_BANKS-1:0]    ld_data,
    input  fv_pkg::bank_addr_t [fv_pkg::NUM_BANKS-1:0]  ld_a,
    output logic [fv_pkg::NUM_EDGE_PE-1:0]              pe_valid,
    output logic [fv_pkg::NUM_EDGE_PE-1:0]              pe_sos,
    output logic [fv_pkg::NUM_EDGE_PE-1:0]              pe_eos,
    output fv_pkg::fv_data_t [fv_pkg::NUM_EDGE_PE-1:0]  pe_data,
    output logic                                        wfull
);
    import fv_pkg::*;

    logic                        rinc;
    logic                        rempty;
    fv_addr_t                    rdata_addr;
    pe_tag_t                     rdata_tag;
    logic [NUM_BANKS-1:0]        bank_busy;
    logic [NUM_BANKS-1:0]        start;
    bank_addr_t                  start_addr;
    pe_tag_t                     start_tag;
    fv_data_t [NUM_BANKS-1:0]    sram_q;

    fv_sram_if   sram_port [NUM_BANKS] ();
    fv_stream_if pe_stream [NUM_BANKS] ();

    fv_sync_fifo fifo_i (
        .clk        (clk),
        .reset      (reset),
        .winc       (wdata_valid),
        .wdata_addr (wdata_fv_addr),
        .wdata_tag  (wdata_pe_tag),
        .rinc       (rinc),
        .wfull      (wfull),
        .rempty     (rempty),
        .rdata_addr (rdata_addr),
        .rdata_tag  (rdata_tag)
    );

    fv_mem_cntl mem_cntl_i (
        .clk        (clk),
        .reset      (reset),
        .rempty     (rempty),
        .rdata_addr (rdata_addr),
        .rdata_tag  (rdata_tag),
        .bank_busy  (bank_busy),
        .rinc       (rinc),
        .start      (start),
        .start_addr (start_addr),
        .start_tag  (start_tag)
    );

    // start address and tag are shared, only the addressed bank sees start
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        fv_bank_cntl bank_cntl_i (
            .clk        (clk),
            .reset      (reset),
            .num_fv     (num_fv),
            .start      (start[i]),
            .start_addr (start_addr),
            .start_tag  (start_tag),
            .ld_sos     (ld_sos[i]),
            .ld_eos     (ld_eos[i]),
            .ld_a       (ld_a[i]),
            .ld_data    (ld_data[i]),
            .sram_q     (sram_q[i]),
            .sram       (sram_port[i]),
            .pe         (pe_stream[i]),
            .busy       (bank_busy[i])
        );

        fv_sram sram_i (
            .clk  (clk),
            .sram (sram_port[i]),
            .q    (sram_q[i])
        );
    end

    fv_bus bus_i (
        .clk      (clk),
        .reset    (reset),
        .bank     (pe_stream),
        .pe_valid (pe_valid),
        .pe_sos   (pe_sos),
        .pe_eos   (pe_eos),
        .pe_data  (pe_data)
    );

endmodule

//--- design/fv_sync_fifo.sv
// request FIFO, first word falls through to rdata so the memory controller sees the head at once
`timescale 1ns/1ps

module fv_sync_fifo (
    input  logic              clk,
    input  logic              reset,
    input  logic              winc,
    input  fv_pkg::fv_addr_t  wdata_addr,
    input  fv_pkg::pe_tag_t   wdata_tag,
    input  logic              rinc,
    output logic              wfull,
    output logic              rempty,
    output fv_pkg::fv_addr_t  rdata_addr,
    output fv_pkg::pe_tag_t   rdata_tag
);
    import fv_pkg::*;

    fv_addr_t                  addr_mem [FIFO_DEPTH];
    pe_tag_t                   tag_mem  [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0]   count;
    logic                      do_wr;
    logic                      do_rd;

    assign wfull  = (count == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign rempty = (count == '0);
    assign do_wr  = winc && !wfull;
    assign do_rd  = rinc && !rempty;

    assign rdata_addr = addr_mem[rd_ptr];
    assign rdata_tag  = tag_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            addr_mem[wr_ptr] <= wdata_addr;
            tag_mem[wr_ptr]  <= wdata_tag;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // source must hold off on wfull
    a_no_write_full: assert property (@(posedge clk) disable iff (reset) winc |-> !wfull);
    // controller only pops a present head
    a_no_read_empty: assert property (@(posedge clk) disable iff (reset) rinc |-> !rempty);

endmodule

//--- files.f
design/fv_pkg.sv
design/fv_ifs.sv
design/fv_sync_fifo.sv
design/fv_mem_cntl.sv
design/fv_bank_cntl.sv
design/fv_sram.sv
design/fv_bus.sv
design/fv_sram_top.sv
verif/fv_sram_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module fv_sram_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vfv_sram_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- verif/fv_input.txt
# test <name> | idle <cycles> | nfv <num_fv> | load <bank> <start word> <length> | check_full
# req <fv addr hex> <pe tag> [<count> <addr step hex>], fv addr = word * 4 + bank
test reset_idle
idle 20
test single_burst
load 0 0 56
load 1 250 16
load 2 16 16
load 3 32 16
nfv 4
req 014 2
test burst_lengths
nfv 1
req 083 1
nfv 5
req 052 3
nfv 8
req 3f9 0
test four_banks
req 028 1
req 001 2
req 042 3
req 093 0
test one_pe_order
nfv 3
req 0a3 2
req 078 2
req 066 2
req 009 2
test fifo_full
nfv 8
req 000 1 12 10
check_full

//--- verif/fv_sram_tb.sv
// testbench for fv_sram_top driven by verif/fv_input.txt and built from files.f
`timescale 1ns/1ps

module fv_sram_tb;
    import fv_pkg::*;

    logic                        clk;
    logic                        reset;
    logic                        wdata_valid;
    fv_addr_t                    wdata_fv_addr;
    pe_tag_t                     wdata_pe_tag;
    fv_num_t                     num_fv;
    logic [NUM_BANKS-1:0]        ld_sos;
    logic [NUM_BANKS-1:0]        ld_eos;
    fv_data_t [NUM_BANKS-1:0]    ld_data;
    bank_addr_t [NUM_BANKS-1:0]  ld_a;
    logic [NUM_EDGE_PE-1:0]      pe_valid;
    logic [NUM_EDGE_PE-1:0]      pe_sos;
    logic [NUM_EDGE_PE-1:0]      pe_eos;
    fv_data_t [NUM_EDGE_PE-1:0]  pe_data;
    logic                        wfull;

    // reference model state
    fv_data_t    mirror [NUM_BANKS][SRAM_DEPTH];
    fv_data_t    exp_words [NUM_EDGE_PE][$];
    int          exp_len [NUM_EDGE_PE][$];
    bit          in_burst [NUM_EDGE_PE];
    int          pos [NUM_EDGE_PE];
    int          cur_len [NUM_EDGE_PE];
    logic [16:0] lfsr = 17'd94096;
    int          cur_nfv;
    bit          saw_full;

    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    test_err_base;
    string cur_test = "";
    int    budget;
    bit    budget_ready;

    fv_sram_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .wdata_valid   (wdata_valid),
        .wdata_fv_addr (wdata_fv_addr),
        .wdata_pe_tag  (wdata_pe_tag),
        .num_fv        (num_fv),
        .ld_sos        (ld_sos),
        .ld_eos        (ld_eos),
        .ld_data       (ld_data),
        .ld_a          (ld_a),
        .pe_valid      (pe_valid),
        .pe_sos        (pe_sos),
        .pe_eos        (pe_eos),
        .pe_data       (pe_data),
        .wfull         (wfull)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic next_word(output fv_data_t w);
        w = '0;
        for (int i = 0; i < FV_BANDWIDTH; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[FV_BANDWIDTH-2:0], lfsr[0]};
        end
    endtask

    task automatic compare_data(input int pe, input fv_data_t got, input fv_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: PE %0d data %h, expected %h", $time, pe, got, exp);
        end
    endtask

    // bits are {valid, sos, eos}
    task automatic compare_frame(input int pe, input logic [2:0] got, input logic [2:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: PE %0d valid/sos/eos %b, expected %b",
                     $time, pe, got, exp);
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic bit pending();
        for (int p = 0; p < NUM_EDGE_PE; p++) begin
            if (in_burst[p] || exp_len[p].size() != 0)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // PE monitors sample the outputs mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (wfull)
                saw_full = 1'b1;
            for (int p = 0; p < NUM_EDGE_PE; p++) begin
                if (pe_valid[p] && !in_burst[p]) begin
                    if (exp_len[p].size() == 0) begin
                        errors++;
                        $display("PE %0d got a burst that no request asked for at %0t ns",
                                 p, $time);
                    end else begin
                        cur_len[p]  = exp_len[p].pop_front();
                        pos[p]      = 0;
                        in_burst[p] = 1'b1;
                    end
                end
                if (in_burst[p]) begin
                    compare_frame(p, {pe_valid[p], pe_sos[p], pe_eos[p]},
                                  {1'b1, pos[p] == 0, pos[p] == cur_len[p] - 1});
                    if (pe_valid[p]) begin
                        compare_data(p, pe_data[p], exp_words[p].pop_front());
                        pos[p]++;
                        if (pos[p] == cur_len[p])
                            in_burst[p] = 1'b0;
                    end
                end
            end
        end
    end

    // wait until every expected burst came back
    task automatic drain();
        @(negedge clk);
        wdata_valid = 1'b0;
        while (pending())
            @(posedge clk);
    endtask

    task automatic close_test();
        drain();
        if (cur_test != "") begin
            tests_run++;
            if (errors == test_err_base) begin
                $display("test %s: ok", cur_test);
            end else begin
                tests_failed++;
                $display("test %s: %0d errors", cur_test, errors - test_err_base);
            end
        end
        test_err_base = errors;
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_flag("wfull", wfull, 1'b0);
            for (int p = 0; p < NUM_EDGE_PE; p++)
                compare_frame(p, {pe_valid[p], pe_sos[p], pe_eos[p]}, 3'b000);
        end
    endtask

    task automatic load_bank(input int b, input bank_addr_t start, input int len);
        fv_data_t   w;
        bank_addr_t a;
        a = start;
        for (int k = 0; k < len; k++) begin
            next_word(w);
            @(negedge clk);
            ld_sos[b]    = (k == 0);
            ld_eos[b]    = (k == len - 1);
            ld_a[b]      = a;
            ld_data[b]   = w;
            mirror[b][a] = w;
            a++;
        end
        @(negedge clk);
        ld_sos[b] = 1'b0;
        ld_eos[b] = 1'b0;
    endtask

    // low bits pick the bank and upper bits the word
    task automatic send_req(input fv_addr_t addr, input pe_tag_t tag);
        bank_sel_t  b;
        bank_addr_t wa;
        b  = addr[BANK_SEL_WIDTH-1:0];
        wa = addr[FV_INFO_BANK_WIDTH-1:BANK_SEL_WIDTH];
        @(negedge clk);
        wdata_valid = 1'b0;
        while (wfull)
            @(negedge clk);
        wdata_valid   = 1'b1;
        wdata_fv_addr = addr;
        wdata_pe_tag  = tag;
        for (int k = 0; k < cur_nfv; k++) begin
            exp_words[tag].push_back(mirror[b][wa]);
            wa++;
        end
        exp_len[tag].push_back(cur_nfv);
    endtask

    // dry pass only sums the cycle budget for the watchdog
    task automatic run_file(input bit dry);
        int    fd;
        int    n;
        int    a1;
        int    a2;
        int    a3;
        int    a4;
        string line;
        string cmd;
        string name;
        fd = $fopen("verif/fv_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/fv_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s", cmd);
                if (n < 1 || cmd.substr(0, 0) == "#")
                    continue;
                if (cmd == "test") begin
                    n = $sscanf(line, "%s %s", cmd, name);
                    if (dry) begin
                        budget += 8;
                    end else begin
                        close_test();
                        cur_test = name;
                    end
                end else if (cmd == "idle") begin
                    n = $sscanf(line, "%s %d", cmd, a1);
                    if (dry)
                        budget += a1 + 4;
                    else begin
                        drain();
                        watch_idle(a1);
                    end
                end else if (cmd == "nfv") begin
                    n = $sscanf(line, "%s %d", cmd, a1);
                    if (!dry) begin
                        drain();
                        cur_nfv = a1;
                        num_fv  = fv_num_t'(a1);
                    end
                end else if (cmd == "load") begin
                    n = $sscanf(line, "%s %d %d %d", cmd, a1, a2, a3);
                    if (dry)
                        budget += a3 + 4;
                    else begin
                        drain();
                        load_bank(a1, bank_addr_t'(a2), a3);
                    end
                end else if (cmd == "req") begin
                    n = $sscanf(line, "%s %h %d %d %h", cmd, a1, a2, a3, a4);
                    if (n < 4) begin
                        a3 = 1;
                        a4 = 0;
                    end
                    if (dry)
                        budget += 64 * a3;
                    else begin
                        for (int r = 0; r < a3; r++)
                            send_req(fv_addr_t'(a1 + r * a4), pe_tag_t'(a2));
                    end
                end else if (cmd == "check_full") begin
                    if (!dry)
                        compare_flag("wfull seen high", saw_full, 1'b1);
                end else if (!dry) begin
                    errors++;
                    $display("unknown command in data file: %s", cmd);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        reset         = 1'b1;
        wdata_valid   = 1'b0;
        wdata_fv_addr = '0;
        wdata_pe_tag  = '0;
        num_fv        = fv_num_t'(1);
        cur_nfv       = 1;
        ld_sos        = '0;
        ld_eos        = '0;
        ld_data       = '0;
        ld_a          = '0;
        budget        = 16 + 200;
        run_file(1'b1);
        budget_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_file(1'b0);
        close_test();
        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        wait (budget_ready);
        repeat (budget) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", budget);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
